// File: compile.f
+incdir+logic
+incdir+tb
logic/cplx_pkg.sv
logic/dsp_alu.sv
logic/cplx_op_decoder.sv
logic/complex_alu.sv
logic/cplx_pipe_ctrl.sv
logic/cplx_mac_top.sv
tb/cplx_mac_tb.sv

// File: logic/complex_alu.sv
`timescale 1ns/1ps
`include "cplx_defines.svh"

module complex_alu (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            ce_i,
	input  cplx_pkg::cplx_t din_1_i, // a + jb
	input  cplx_pkg::cplx_t din_2_i, // c + jd
	input  logic [`CPLX_NUM_CORES*`CPLX_ALUMODE_WIDTH-1:0] alumode_i,
	input  logic [`CPLX_NUM_CORES*`CPLX_OPMODE_WIDTH-1:0]  opmode_i,
	output cplx_pkg::cplx_t dout_o
);
	import cplx_pkg::*;

	localparam int NC = `CPLX_NUM_CORES;
	localparam int AX = `CPLX_PORTA_WIDTH - `CPLX_DATA_WIDTH; // a port sign bits
	localparam int BX = `CPLX_PORTB_WIDTH - `CPLX_DATA_WIDTH; // b port sign bits

	sample_t a_s, b_s, c_s, d_s;
	porta_t  a_op [NC]; // index 0 is core 1
	portb_t  b_op [NC];
	portp_t  p_res [NC];
	portp_t  i_sum, q_sum;
	sample_t i_res, q_res;
	cplx_t   dout_q;

	assign a_s = din_1_i[2*`CPLX_DATA_WIDTH-1:`CPLX_DATA_WIDTH];
	assign b_s = din_1_i[`CPLX_DATA_WIDTH-1:0];
	assign c_s = din_2_i[2*`CPLX_DATA_WIDTH-1:`CPLX_DATA_WIDTH];
	assign d_s = din_2_i[`CPLX_DATA_WIDTH-1:0];

	//////////////////////////////////////////////////
	// operand map, second factor on A
	//////////////////////////////////////////////////
	assign a_op[0] = {{AX{c_s[`CPLX_DATA_WIDTH-1]}}, c_s}; // ac
	assign b_op[0] = {{BX{a_s[`CPLX_DATA_WIDTH-1]}}, a_s};
	assign a_op[1] = {{AX{d_s[`CPLX_DATA_WIDTH-1]}}, d_s}; // bd
	assign b_op[1] = {{BX{b_s[`CPLX_DATA_WIDTH-1]}}, b_s};
	assign a_op[2] = {{AX{c_s[`CPLX_DATA_WIDTH-1]}}, c_s}; // bc
	assign b_op[2] = {{BX{b_s[`CPLX_DATA_WIDTH-1]}}, b_s};
	assign a_op[3] = {{AX{d_s[`CPLX_DATA_WIDTH-1]}}, d_s}; // ad
	assign b_op[3] = {{BX{a_s[`CPLX_DATA_WIDTH-1]}}, a_s};

	for (genvar k = 0; k < NC; k++) begin : g_core
		dsp_alu u_dsp (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.ce_i      (ce_i),
			.a_i       (a_op[k]),
			.b_i       (b_op[k]),
			.alumode_i (alumode_i[(NC-1-k)*`CPLX_ALUMODE_WIDTH +: `CPLX_ALUMODE_WIDTH]),
			.opmode_i  (opmode_i[(NC-1-k)*`CPLX_OPMODE_WIDTH +: `CPLX_OPMODE_WIDTH]),
			.p_o       (p_res[k])
		);
	end

	//////////////////////////////////////////////////
	// combine, scale, wrap to 16 bits
	//////////////////////////////////////////////////
	assign i_sum = p_res[0] + p_res[1]; // sign of bd set by alumode
	assign q_sum = p_res[2] + p_res[3]; // sign of ad set by alumode
	assign i_res = sample_t'(i_sum >> `CPLX_FRAC_BITS); // plain truncation
	assign q_res = sample_t'(q_sum >> `CPLX_FRAC_BITS);

	always_ff @(posedge clk) begin
		if (ce_i) begin
			dout_q <= {i_res, q_res};
		end
	end

	assign dout_o = dout_q;

endmodule

// File: logic/cplx_defines.svh
`ifndef CPLX_DEFINES_SVH
`define CPLX_DEFINES_SVH

// datapath widths
`define CPLX_DATA_WIDTH    16  // one I or Q part, Q1.15
`define CPLX_PORTA_WIDTH   30  // core A port
`define CPLX_PORTB_WIDTH   18  // core B port
`define CPLX_PORTP_WIDTH   48  // core P / accumulator
`define CPLX_FRAC_BITS     15  // combine stage scaling shift
`define CPLX_ALU_LAT       3   // A/B, M, P register stages
`define CPLX_NUM_CORES     4   // ac, bd, bc, ad

// op codes carried with each beat
`define CPLX_OP_MUL        2'b00  // (a+jb)(c+jd)
`define CPLX_OP_CMUL       2'b01  // (a+jb)(c-jd)
`define CPLX_OP_MAC        2'b10  // running sum of (a+jb)(c+jd)

// core ALU mode, 4 bits per core
`define CPLX_ALUMODE_WIDTH 4
`define CPLX_ALUMODE_ADD   4'b0000  // z + x
`define CPLX_ALUMODE_NEG   4'b0011  // z - x

// core operation mode, {z[2:0], y/x[3:0]}
`define CPLX_OPMODE_WIDTH  7
`define CPLX_OPM_X_WIDTH   4
`define CPLX_OPM_X_ZERO    4'b0000  // x = 0
`define CPLX_OPM_X_MULT    4'b0101  // x = m
`define CPLX_OPM_Z_ZERO    3'b000   // z = 0
`define CPLX_OPM_Z_P       3'b010   // z = p, accumulate

`endif

// File: logic/cplx_mac_top.sv
`timescale 1ns/1ps
`include "cplx_defines.svh"

module cplx_mac_top (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               in_valid_i,
	input  cplx_pkg::cplx_op_t op_i,
	input  logic               acc_first_i,
	input  cplx_pkg::cplx_t    din_1_i,     // a + jb
	input  cplx_pkg::cplx_t    din_2_i,     // c + jd
	input  logic               out_ready_i,
	output logic               in_ready_o,
	output logic               out_valid_o,
	output cplx_pkg::cplx_t    dout_o
);

	logic pipe_ce; // freezes every stage on stall
	logic in_fire;
	logic [`CPLX_NUM_CORES*`CPLX_ALUMODE_WIDTH-1:0] core_alumode; // core 1 in msbs
	logic [`CPLX_NUM_CORES*`CPLX_OPMODE_WIDTH-1:0]  core_opmode;

	cplx_pipe_ctrl u_ctrl (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (in_valid_i),
		.out_ready_i (out_ready_i),
		.in_ready_o  (in_ready_o),
		.in_fire_o   (in_fire),
		.ce_o        (pipe_ce),
		.out_valid_o (out_valid_o)
	);

	cplx_op_decoder u_dec (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.ce_i        (pipe_ce),
		.in_fire_i   (in_fire),
		.op_i        (op_i),
		.acc_first_i (acc_first_i),
		.alumode_o   (core_alumode),
		.opmode_o    (core_opmode)
	);

	complex_alu u_alu (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.ce_i      (pipe_ce),
		.din_1_i   (din_1_i),
		.din_2_i   (din_2_i),
		.alumode_i (core_alumode),
		.opmode_i  (core_opmode),
		.dout_o    (dout_o)
	);

endmodule

// File: logic/cplx_op_decoder.sv
`timescale 1ns/1ps
`include "cplx_defines.svh"

module cplx_op_decoder (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                ce_i,        // pipeline advance
	input  logic                in_fire_i,   // beat accepted this edge
	input  cplx_pkg::cplx_op_t  op_i,
	input  logic                acc_first_i, // restart MAC sum
	output logic [`CPLX_NUM_CORES*`CPLX_ALUMODE_WIDTH-1:0] alumode_o,
	output logic [`CPLX_NUM_CORES*`CPLX_OPMODE_WIDTH-1:0]  opmode_o
);
	import cplx_pkg::*;

	localparam int NC      = `CPLX_NUM_CORES;
	localparam int DLY     = `CPLX_ALU_LAT - 1; // decode to P stage
	localparam int CORE_BD = NC - 2;            // core 2 slice
	localparam int CORE_AD = NC - 4;            // core 4 slice

	localparam opmode_t OPM_BUBBLE = {`CPLX_OPM_Z_P, `CPLX_OPM_X_ZERO};    // hold p
	localparam opmode_t OPM_PROD   = {`CPLX_OPM_Z_ZERO, `CPLX_OPM_X_MULT}; // p = +-m
	localparam opmode_t OPM_ACC    = {`CPLX_OPM_Z_P, `CPLX_OPM_X_MULT};    // p = p +- m

	alumode_t [NC-1:0] alu_d; // core 1 in msb slice
	opmode_t  [NC-1:0] opm_d;
	alumode_t [NC-1:0] alu_q [DLY];
	opmode_t  [NC-1:0] opm_q [DLY];

	always_comb begin
		alu_d = {NC{`CPLX_ALUMODE_ADD}};
		opm_d = {NC{OPM_BUBBLE}}; // idle cycles keep every sum
		if (in_fire_i) begin
			case (op_i)
				`CPLX_OP_MUL: begin
					alu_d[CORE_BD] = `CPLX_ALUMODE_NEG; // ac - bd
					opm_d          = {NC{OPM_PROD}};
				end
				`CPLX_OP_CMUL: begin
					alu_d[CORE_AD] = `CPLX_ALUMODE_NEG; // bc - ad
					opm_d          = {NC{OPM_PROD}};
				end
				`CPLX_OP_MAC: begin
					alu_d[CORE_BD] = `CPLX_ALUMODE_NEG;
					opm_d          = acc_first_i ? {NC{OPM_PROD}} : {NC{OPM_ACC}};
				end
				default: ; // unused code, left as bubble
			endcase
		end
	end

	// line the modes up with the product
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < DLY; i++) begin
				alu_q[i] <= {NC{`CPLX_ALUMODE_ADD}};
				opm_q[i] <= {NC{OPM_BUBBLE}};
			end
		end else if (ce_i) begin
			alu_q[0] <= alu_d;
			opm_q[0] <= opm_d;
			for (int i = 1; i < DLY; i++) begin
				alu_q[i] <= alu_q[i-1];
				opm_q[i] <= opm_q[i-1];
			end
		end
	end

	assign alumode_o = alu_q[DLY-1];
	assign opmode_o  = opm_q[DLY-1];

	a_op_known: assert property (@(posedge clk) disable iff (!arst_n_i)
		in_fire_i |-> op_i inside {`CPLX_OP_MUL, `CPLX_OP_CMUL, `CPLX_OP_MAC})
		else $error("cplx_op_decoder: accepted undefined op %b", op_i);

endmodule

// File: logic/cplx_pipe_ctrl.sv
`timescale 1ns/1ps
`include "cplx_defines.svh"

module cplx_pipe_ctrl (
	input  logic clk,
	input  logic arst_n_i,
	input  logic in_valid_i,
	input  logic out_ready_i,
	output logic in_ready_o,
	output logic in_fire_o,   // beat accepted
	output logic ce_o,        // global pipeline enable
	output logic out_valid_o
);

	localparam int DEPTH = `CPLX_ALU_LAT + 1; // core stages plus combine reg

	logic [DEPTH-1:0] vld_q; // bit 0 is the operand stage

	// stall only when a finished result is not taken
	assign ce_o        = !(vld_q[DEPTH-1] && !out_ready_i);
	assign in_ready_o  = ce_o;
	assign in_fire_o   = in_valid_i && ce_o;
	assign out_valid_o = vld_q[DEPTH-1];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vld_q <= '0;
		end else if (ce_o) begin
			vld_q <= {vld_q[DEPTH-2:0], in_fire_o}; // shift in with the data
		end
	end

	// a held result must survive until it is taken
	a_out_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o)
		else $error("cplx_pipe_ctrl: result dropped under back-pressure");

endmodule

// File: logic/cplx_pkg.sv
`include "cplx_defines.svh"

package cplx_pkg;

	//////////////////////////////////////////////////
	// sample and complex word
	//////////////////////////////////////////////////

	// one Q1.15 part
	typedef logic [`CPLX_DATA_WIDTH-1:0] sample_t;

	// I in upper half, Q in lower half
	typedef logic [2*`CPLX_DATA_WIDTH-1:0] cplx_t;

	typedef logic [1:0] cplx_op_t; // MUL, CMUL, MAC

	//////////////////////////////////////////////////
	// core ports and mode fields
	//////////////////////////////////////////////////

	typedef logic [`CPLX_PORTA_WIDTH-1:0] porta_t; // carries c or d
	typedef logic [`CPLX_PORTB_WIDTH-1:0] portb_t; // carries a or b
	typedef logic [`CPLX_PORTP_WIDTH-1:0] portp_t; // product and sum

	typedef logic [`CPLX_ALUMODE_WIDTH-1:0] alumode_t;
	typedef logic [`CPLX_OPMODE_WIDTH-1:0]  opmode_t;

endpackage

// File: logic/dsp_alu.sv
`timescale 1ns/1ps
`include "cplx_defines.svh"

module dsp_alu (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              ce_i,       // pipeline advance
	input  cplx_pkg::porta_t   a_i,
	input  cplx_pkg::portb_t   b_i,
	input  cplx_pkg::alumode_t alumode_i,  // valid at the P stage
	input  cplx_pkg::opmode_t  opmode_i,   // valid at the P stage
	output cplx_pkg::portp_t   p_o
);
	import cplx_pkg::*;

	porta_t a_q; // operand regs
	portb_t b_q;
	portp_t m_q; // product reg
	portp_t p_q; // accumulator
	portp_t x_mux;
	portp_t z_mux;

	logic [`CPLX_OPM_X_WIDTH-1:0]                    opm_x; // x select
	logic [`CPLX_OPMODE_WIDTH-`CPLX_OPM_X_WIDTH-1:0] opm_z; // z select

	assign opm_x = opmode_i[`CPLX_OPM_X_WIDTH-1:0];
	assign opm_z = opmode_i[`CPLX_OPMODE_WIDTH-1:`CPLX_OPM_X_WIDTH];

	// stages 1 and 2, operands then signed product
	always_ff @(posedge clk) begin
		if (ce_i) begin
			a_q <= a_i;
			b_q <= b_i;
			m_q <= $signed(a_q) * $signed(b_q); // 30x18 fits 48
		end
	end

	always_comb begin
		case (opm_x)
			`CPLX_OPM_X_MULT: x_mux = m_q;
			default:          x_mux = '0; // bubble, no product
		endcase
		case (opm_z)
			`CPLX_OPM_Z_P: z_mux = p_q; // feedback
			default:       z_mux = '0;  // fresh start
		endcase
	end

	// stage 3, post adder
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			p_q <= '0;
		end else if (ce_i) begin
			case (alumode_i)
				`CPLX_ALUMODE_NEG: p_q <= z_mux - x_mux;
				default:           p_q <= z_mux + x_mux;
			endcase
		end
	end

	assign p_o = p_q;

	// decoder must only ever hand us the two x and two z codes
	property p_opmode_legal;
		@(posedge clk) disable iff (!arst_n_i)
		ce_i |-> (opm_x inside {`CPLX_OPM_X_ZERO, `CPLX_OPM_X_MULT}) &&
			(opm_z inside {`CPLX_OPM_Z_ZERO, `CPLX_OPM_Z_P});
	endproperty
	a_opmode_legal: assert property (p_opmode_legal)
		else $error("dsp_alu: undefined opmode field %b", opmode_i);

endmodule

// File: tb/cplx_tb_model.svh
`ifndef CPLX_TB_MODEL_SVH
`define CPLX_TB_MODEL_SVH

// running complex sum, full precision
longint acc_re = 0;
longint acc_im = 0;

// Q2.30 sum back to one Q1.15 part, truncate and wrap
function automatic logic [15:0] scale_part(input longint v);
	longint s;
	s = v >>> `CPLX_FRAC_BITS;
	return s[15:0];
endfunction

function automatic logic [31:0] expected_result(input logic [1:0] op, input logic first,
	input logic [31:0] x, input logic [31:0] y);
	longint a;
	longint b;
	longint c;
	longint d;
	longint re;
	longint im;
	a = longint'($signed(x[31:16])); // x = a + jb
	b = longint'($signed(x[15:0]));
	c = longint'($signed(y[31:16])); // y = c + jd
	d = longint'($signed(y[15:0]));
	re = a * c - b * d; // (a+jb)(c+jd)
	im = b * c + a * d;
	if (op == `CPLX_OP_CMUL) begin
		re = a * c + b * d; // second factor conjugated
		im = b * c - a * d;
	end else if (op == `CPLX_OP_MAC && !first) begin
		re = re + acc_re; // continue the running sum
		im = im + acc_im;
	end
	acc_re = re; // every product becomes the new sum
	acc_im = im;
	return {scale_part(re), scale_part(im)};
endfunction

`endif

// File: tb/cplx_mac_tb.sv
`timescale 1ns/1ps
`include "cplx_defines.svh"

module cplx_mac_tb;
	import cplx_pkg::*;

	localparam int LATENCY = 4;   // accept edge to result transfer edge
	localparam int TIMEOUT = 200; // cycles allowed per wait
	localparam int PAT_LEN = 1024;

	logic     clk = 1'b0;
	logic     arst_n_i;
	logic     in_valid_i;
	cplx_op_t op_i;
	logic     acc_first_i;
	cplx_t    din_1_i;
	cplx_t    din_2_i;
	logic     out_ready_i;
	logic     in_ready_o;
	logic     out_valid_o;
	cplx_t    dout_o;

	cplx_t  exp_q [$];     // scoreboard
	longint acc_cyc_q [$]; // accept cycle of each beat
	bit     ready_pat [PAT_LEN];
	bit     ready_random = 1'b0;
	bit     strict_timing = 1'b1;
	bit     held_valid = 1'b0;
	cplx_t  held_data;
	longint cycle_cnt = 0;
	int     mismatch_count = 0;
	int     timeout_count = 0;
	int     protocol_count = 0;
	int     accepted_count = 0;
	int     result_count = 0;

	`include "cplx_tb_model.svh"

	cplx_mac_top dut (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (in_valid_i),
		.op_i        (op_i),
		.acc_first_i (acc_first_i),
		.din_1_i     (din_1_i),
		.din_2_i     (din_2_i),
		.out_ready_i (out_ready_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.dout_o      (dout_o)
	);

	always #2 clk = ~clk; // 4 ns period

	// sink side, back-pressure from a fixed pattern
	always @(negedge clk) begin
		if (ready_random)
			out_ready_i = ready_pat[cycle_cnt % PAT_LEN];
		else
			out_ready_i = 1'b1;
	end

	//////////////////////////////////////////////////
	// compare and report
	//////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("Error counts: %0d mismatches, %0d timeouts, %0d protocol errors",
			mismatch_count, timeout_count, protocol_count);
		if (mismatch_count + timeout_count + protocol_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeout_count++;
		$display("Timeout at %0t: %s did not arrive within %0d cycles", $time, what, TIMEOUT);
		finish_run();
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	task automatic send_beat(input cplx_op_t op, input logic first);
		int waited;
		waited = 0;
		in_valid_i  = 1'b1;
		op_i        = op;
		acc_first_i = first;
		din_1_i     = $urandom;
		din_2_i     = $urandom;
		@(posedge clk);
		while (!in_ready_o) begin // payload held while stalled
			waited++;
			if (waited > TIMEOUT)
				report_timeout("in_ready_o for a pending beat");
			@(posedge clk);
		end
		@(negedge clk);
	endtask

	task automatic idle_cycles(input int n);
		in_valid_i = 1'b0;
		din_1_i    = $urandom; // junk, must be ignored
		din_2_i    = $urandom;
		repeat (n) @(negedge clk);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		in_valid_i = 1'b0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > TIMEOUT)
				report_timeout("the outstanding results");
			@(negedge clk);
		end
	endtask

	// monitor and checker, sampled on the rising edge
	always @(posedge clk) begin
		longint acc_cyc;
		if (arst_n_i) begin
			cycle_cnt++;
			if (held_valid) begin // result held under back-pressure
				check_value("out_valid_o", out_valid_o, 1'b1);
				check_value("dout_o (held)", dout_o, held_data);
			end
			if (in_valid_i && in_ready_o) begin
				exp_q.push_back(expected_result(op_i, acc_first_i, din_1_i, din_2_i));
				acc_cyc_q.push_back(cycle_cnt);
				accepted_count++;
			end
			if (out_valid_o && out_ready_i) begin
				result_count++; // every transfer, expected or not
				if (exp_q.size() == 0) begin
					protocol_count++;
					$display("Error at %0t: a result came out with no beat outstanding", $time);
				end else begin
					acc_cyc = acc_cyc_q.pop_front();
					check_value("dout_o", dout_o, exp_q.pop_front());
					if (strict_timing)
						check_value("latency", cycle_cnt - acc_cyc, LATENCY);
				end
			end
			held_valid = out_valid_o && !out_ready_i;
			held_data  = dout_o;
		end
	end

	initial begin
		void'($urandom(10125));
		for (int i = 0; i < PAT_LEN; i++)
			ready_pat[i] = ($urandom_range(0, 99) < 55);
		arst_n_i    = 1'b0;
		in_valid_i  = 1'b0;
		op_i        = `CPLX_OP_MUL;
		acc_first_i = 1'b0;
		din_1_i     = '0;
		din_2_i     = '0;
		out_ready_i = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;
		check_value("out_valid_o", out_valid_o, 1'b0); // idle after reset
		check_value("in_ready_o", in_ready_o, 1'b1);

		repeat (40) send_beat(`CPLX_OP_MUL, 1'b0); // back to back
		drain();
		repeat (30) send_beat(`CPLX_OP_CMUL, 1'(($urandom_range(0, 1))));
		drain();

		// MAC run with gaps and the odd restart
		send_beat(`CPLX_OP_MAC, 1'b1);
		for (int i = 0; i < 60; i++) begin
			idle_cycles($urandom_range(0, 3));
			send_beat(`CPLX_OP_MAC, $urandom_range(0, 7) == 0);
		end
		drain();

		// mixed ops under random back-pressure
		strict_timing = 1'b0;
		@(posedge clk);
		ready_random = 1'b1;
		@(negedge clk);
		for (int i = 0; i < 120; i++) begin
			idle_cycles($urandom_range(0, 2));
			send_beat(cplx_op_t'($urandom_range(0, 2)), $urandom_range(0, 3) == 0);
		end
		drain();
		@(posedge clk);
		ready_random = 1'b0;
		@(negedge clk);
		idle_cycles(LATENCY); // quiet window, no late extra result
		check_value("result count", result_count, accepted_count);
		finish_run();
	end

endmodule
